/* hdl/qla_regmap_pkg.sv */
// register map of the controller with 16 bit address and 32 bit data
// address layout is space[15:12] channel[7:4] offset[3:0], bits 11:8 unused
// channel 0 holds the board registers and channels 1 to 4 the motors
`default_nettype none

package qla_regmap_pkg;

    // ----------------------------------------
    // address fields
    // ----------------------------------------
    typedef logic [3:0] addr_space_t;   // addr[15:12]
    typedef logic [3:0] chan_t;         // addr[7:4]

    localparam addr_space_t ADDR_MAIN = 4'h0;  // channel register space

    // offsets within one channel
    typedef enum logic [3:0] {
        OFF_STATUS     = 4'd0,  // board status and control on channel 0
        OFF_DAC_CTRL   = 4'd1,  // commanded current
        OFF_MOTOR_CTRL = 4'd2   // amp enable on write and motor status on read
    } reg_offset_e;

    // ----------------------------------------
    // write data bit positions
    // ----------------------------------------
    localparam int DAC_UPDATE_BIT = 31;  // request a dac frame
    localparam int PWR_MASK_BIT   = 19;  // power enable write mask
    localparam int PWR_VAL_BIT    = 18;
    localparam int AMP_MASK_BIT   = 9;   // amp enable write mask
    localparam int AMP_VAL_BIT    = 8;

endpackage

`default_nettype wire

/* hdl/qla_motor_pkg.sv */
// motor side constants for the quad amplifier
// the channel count is fixed because the register map encodes it
`default_nettype none

package qla_motor_pkg;

    localparam int NUM_CHAN = 4;    // channels 1 to 4

    // commanded current
    localparam int CUR_W = 16;
    typedef logic [CUR_W-1:0] cur_cmd_t;

    // ----------------------------------------
    // quad dac serial word
    // ----------------------------------------
    localparam int DAC_WORD_W = 24;  // cmd + addr + value

    typedef enum logic [3:0] {
        CMD_WRITE_UPDATE = 4'b0011  // write and update one dac
    } dac_cmd_e;

endpackage

`default_nettype wire

/* hdl/motor_cmd_regs.sv */
// motor channel registers on channels 1 to 4 of the main space
// the low 16 write bits set the command and bit 31 requests a dac frame
// amp enable writes need board power and the watchdog timeout clears them
// only one dac request can be pending behind a running frame
`default_nettype none

module motor_cmd_regs (
    input  logic                                sysclk,
    input  logic                                rst,
    input  logic [15:0]                         reg_waddr,
    input  logic [31:0]                         reg_wdata,
    input  logic                                reg_wen,
    input  logic [15:0]                         reg_raddr,
    input  logic [qla_motor_pkg::NUM_CHAN-1:0]  amp_fault,     // 1 means amp good
    input  logic                                pwr_enable,
    input  logic                                wdog_timeout,
    input  logic                                dac_busy,
    output qla_motor_pkg::cur_cmd_t             cur_cmd [qla_motor_pkg::NUM_CHAN],
    output logic                                cur_cmd_updated,
    output logic [qla_motor_pkg::NUM_CHAN-1:0]  amp_enable_cmd, // masked amp write
    output logic [qla_motor_pkg::NUM_CHAN-1:0]  amp_disable,
    output logic [31:0]                         motor_rdata
);

    localparam int NCH = qla_motor_pkg::NUM_CHAN;

    qla_regmap_pkg::chan_t w_chan;
    qla_regmap_pkg::chan_t r_chan;
    logic                  w_main;      // write strobe into main space
    logic                  w_dac;
    logic                  w_motor;
    logic [NCH-1:0]        w_sel;       // one hot channel select
    logic                  upd_wr;      // update request write
    logic                  cmd_req;     // request pending behind busy dac

    // ----------------------------------------
    // write decode
    // ----------------------------------------
    assign w_chan  = reg_waddr[7:4];
    assign r_chan  = reg_raddr[7:4];
    assign w_main  = reg_wen && (reg_waddr[15:12] == qla_regmap_pkg::ADDR_MAIN);
    assign w_dac   = w_main && (reg_waddr[3:0] == qla_regmap_pkg::OFF_DAC_CTRL);
    assign w_motor = w_main && (reg_waddr[3:0] == qla_regmap_pkg::OFF_MOTOR_CTRL);
    assign upd_wr  = w_dac && (|w_sel) && reg_wdata[qla_regmap_pkg::DAC_UPDATE_BIT];

    always_comb begin
        for (int i = 0; i < NCH; i++) begin
            w_sel[i] = (w_chan == qla_regmap_pkg::chan_t'(i + 1));
            amp_enable_cmd[i] = w_motor && w_sel[i]
                                && reg_wdata[qla_regmap_pkg::AMP_MASK_BIT];
        end
    end

    // commanded current per channel
    always_ff @(posedge sysclk) begin
        for (int i = 0; i < NCH; i++) begin
            if (rst) begin
                cur_cmd[i] <= '0;
            end else if (w_dac && w_sel[i]) begin
                cur_cmd[i] <= reg_wdata[qla_motor_pkg::CUR_W-1:0];
            end
        end
    end

    // amp disable holds the inverse of the enable
    always_ff @(posedge sysclk) begin
        if (rst || wdog_timeout) begin
            amp_disable <= '1;
        end else begin
            for (int i = 0; i < NCH; i++) begin
                if (amp_enable_cmd[i] && pwr_enable) begin    // no enable without power
                    amp_disable[i] <= ~reg_wdata[qla_regmap_pkg::AMP_VAL_BIT];
                end
            end
        end
    end

    // ----------------------------------------
    // dac request and pending latch
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            cmd_req         <= 1'b0;
            cur_cmd_updated <= 1'b0;
        end else if (upd_wr) begin
            // a raised request is taken on this edge with the old values
            // so a new one goes pending as well
            cmd_req         <= dac_busy || cur_cmd_updated;
            cur_cmd_updated <= !dac_busy && !cur_cmd_updated;
        end else if (cmd_req && !dac_busy) begin
            cmd_req         <= 1'b0;
            cur_cmd_updated <= 1'b1;      // frame done so issue the pending one
        end else if (cur_cmd_updated && dac_busy) begin
            cur_cmd_updated <= 1'b0;      // dac took it
        end
    end

    // read data for the addressed channel
    always_comb begin
        motor_rdata = '0;
        for (int i = 0; i < NCH; i++) begin
            if (r_chan == qla_regmap_pkg::chan_t'(i + 1)) begin
                case (reg_raddr[3:0])
                    qla_regmap_pkg::OFF_DAC_CTRL:   motor_rdata = 32'(cur_cmd[i]);
                    qla_regmap_pkg::OFF_MOTOR_CTRL: motor_rdata = {30'd0, amp_fault[i],
                                                                   ~amp_disable[i]};
                    default:                        motor_rdata = '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/dac_spi_ctrl.sv */
// serializer for one quad 16 bit dac in spi mode 0 and msb first
// a frame is four 24 bit words starting with channel 1
// sclk half period and the csel gap between words are SCLK_DIV sysclk cycles
// commands are captured when a frame starts and later changes wait
`default_nettype none

module dac_spi_ctrl #(
    parameter int SCLK_DIV = 2                  // sysclk cycles per sclk half period
) (
    input  logic                    sysclk,
    input  logic                    rst,
    input  qla_motor_pkg::cur_cmd_t cur_cmd [qla_motor_pkg::NUM_CHAN],
    input  logic                    cur_cmd_updated,
    output logic                    dac_busy,
    output logic                    dac_sclk,
    output logic                    dac_mosi,
    output logic                    dac_csel    // active low
);

    localparam int NCH   = qla_motor_pkg::NUM_CHAN;
    localparam int WW    = qla_motor_pkg::DAC_WORD_W;
    localparam int DIV_W = $clog2(SCLK_DIV + 1);
    localparam int BIT_W = $clog2(WW);
    localparam int CH_W  = $clog2(NCH);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,   // csel low and clocking bits
        ST_GAP      // csel high between words
    } dac_state_e;

    dac_state_e              state;
    logic [DIV_W-1:0]        div_cnt;
    logic                    tick;       // end of a half period
    logic [BIT_W-1:0]        bit_cnt;
    logic [CH_W-1:0]         word_cnt;
    logic [CH_W-1:0]         next_word;
    logic                    last_word;
    logic [WW-1:0]           shreg;
    qla_motor_pkg::cur_cmd_t snap [NCH];  // frame snapshot

    // command code then channel index minus one then value
    function automatic logic [WW-1:0] dac_word(input logic [CH_W-1:0] idx,
                                               input qla_motor_pkg::cur_cmd_t cmd);
        return {qla_motor_pkg::CMD_WRITE_UPDATE, 4'(idx), cmd};
    endfunction

    assign tick      = (div_cnt == DIV_W'(SCLK_DIV - 1));
    assign next_word = word_cnt + 1'b1;
    assign last_word = (word_cnt == CH_W'(NCH - 1));
    assign dac_busy  = (state != ST_IDLE);
    assign dac_mosi  = shreg[WW-1];

    // ----------------------------------------
    // sclk divider
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst || state == ST_IDLE || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // frame FSM
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            state    <= ST_IDLE;
            dac_sclk <= 1'b0;
            dac_csel <= 1'b1;
            bit_cnt  <= '0;
            word_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cur_cmd_updated) begin
                        state    <= ST_SHIFT;
                        dac_csel <= 1'b0;
                        bit_cnt  <= '0;
                        word_cnt <= '0;
                    end
                end
                ST_SHIFT: begin
                    if (tick && !dac_sclk) begin
                        dac_sclk <= 1'b1;                 // dac samples here
                    end else if (tick) begin
                        dac_sclk <= 1'b0;
                        if (bit_cnt == BIT_W'(WW - 1)) begin
                            state    <= ST_GAP;
                            dac_csel <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                ST_GAP: begin
                    if (tick && last_word) begin
                        state <= ST_IDLE;
                    end else if (tick) begin
                        state    <= ST_SHIFT;
                        dac_csel <= 1'b0;
                        bit_cnt  <= '0;
                        word_cnt <= next_word;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // shift data moves on the falling sclk edge
    always_ff @(posedge sysclk) begin
        if (state == ST_IDLE && cur_cmd_updated) begin
            snap  <= cur_cmd;
            shreg <= dac_word('0, cur_cmd[0]);
        end else if (state == ST_SHIFT && tick && dac_sclk) begin
            shreg <= {shreg[WW-2:0], 1'b0};
        end else if (state == ST_GAP && tick && !last_word) begin
            shreg <= dac_word(next_word, snap[next_word]);
        end
    end

endmodule

`default_nettype wire

/* hdl/board_regs.sv */
// board register at channel 0 offset 0 of the main space
// power enable takes a masked write and the watchdog timeout clears it
// wdog_clear pulses one cycle after any masked power or amp write
`default_nettype none

module board_regs (
    input  logic                                sysclk,
    input  logic                                rst,
    input  logic [15:0]                         reg_waddr,
    input  logic [31:0]                         reg_wdata,
    input  logic                                reg_wen,
    input  logic [3:0]                          board_id,   // rotary switch
    input  logic [qla_motor_pkg::NUM_CHAN-1:0]  amp_fault,
    input  logic                                wdog_timeout,
    input  logic [qla_motor_pkg::NUM_CHAN-1:0]  amp_enable_cmd,
    output logic                                pwr_enable,
    output logic                                wdog_clear,
    output logic [31:0]                         board_rdata
);

    logic pwr_wr;       // write to the status register
    logic pwr_cmd;      // masked power write

    assign pwr_wr = reg_wen
                    && (reg_waddr[15:12] == qla_regmap_pkg::ADDR_MAIN)
                    && (reg_waddr[7:4] == 4'd0)
                    && (reg_waddr[3:0] == qla_regmap_pkg::OFF_STATUS);
    assign pwr_cmd = pwr_wr && reg_wdata[qla_regmap_pkg::PWR_MASK_BIT];

    // ----------------------------------------
    // power enable and watchdog clear
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            pwr_enable <= 1'b0;
            wdog_clear <= 1'b0;
        end else begin
            wdog_clear <= pwr_cmd || (|amp_enable_cmd);   // host wants power
            if (wdog_timeout) begin
                pwr_enable <= 1'b0;
            end else if (pwr_cmd) begin
                pwr_enable <= reg_wdata[qla_regmap_pkg::PWR_VAL_BIT];
            end
        end
    end

    // status word
    assign board_rdata = {4'd0, board_id,       // 31:24
                          12'd0, amp_fault,     // 23:8
                          6'd0, wdog_timeout, pwr_enable};

endmodule

`default_nettype wire

/* hdl/reg_read_mux.sv */
// read data select for the register bus and purely combinational
// anything outside the mapped registers reads as 0
`default_nettype none

module reg_read_mux (
    input  logic [15:0] reg_raddr,
    input  logic [31:0] motor_rdata,
    input  logic [31:0] board_rdata,
    output logic [31:0] reg_rdata
);

    qla_regmap_pkg::chan_t r_chan;
    logic                  r_main;
    logic                  r_board;    // channel 0 status
    logic                  r_motor;    // channels 1 to 4

    assign r_chan  = reg_raddr[7:4];
    assign r_main  = (reg_raddr[15:12] == qla_regmap_pkg::ADDR_MAIN);
    assign r_board = r_main && (r_chan == 4'd0)
                     && (reg_raddr[3:0] == qla_regmap_pkg::OFF_STATUS);
    assign r_motor = r_main && (r_chan != 4'd0)
                     && (r_chan <= qla_regmap_pkg::chan_t'(qla_motor_pkg::NUM_CHAN))
                     && ((reg_raddr[3:0] == qla_regmap_pkg::OFF_DAC_CTRL)
                         || (reg_raddr[3:0] == qla_regmap_pkg::OFF_MOTOR_CTRL));

    assign reg_rdata = r_board ? board_rdata :
                       r_motor ? motor_rdata : 32'd0;

endmodule

`default_nettype wire

/* hdl/qla_core.sv */
// motor command and board control core of the quad amplifier controller
// writes are one cycle reg_wen strobes and reads are combinational
// amp_fault and the watchdog timeout come from outside the core
// SCLK_DIV sets the dac sclk half period in sysclk cycles
`default_nettype none

module qla_core #(
    parameter int SCLK_DIV = 2
) (
    input  logic                                sysclk,
    input  logic                                rst,
    input  logic [3:0]                          board_id,
    input  logic [15:0]                         reg_waddr,
    input  logic [31:0]                         reg_wdata,
    input  logic                                reg_wen,
    input  logic [15:0]                         reg_raddr,
    input  logic [qla_motor_pkg::NUM_CHAN-1:0]  amp_fault,      // 1 means amp good
    input  logic                                wdog_timeout,
    output logic [31:0]                         reg_rdata,
    output logic                                pwr_enable,
    output logic [qla_motor_pkg::NUM_CHAN-1:0]  amp_disable,
    output logic                                wdog_clear,
    output logic                                dac_sclk,
    output logic                                dac_mosi,
    output logic                                dac_csel,
    output logic                                dac_busy
);

    qla_motor_pkg::cur_cmd_t                cur_cmd [qla_motor_pkg::NUM_CHAN];
    logic                                   cur_cmd_updated;   // dac frame request
    logic [qla_motor_pkg::NUM_CHAN-1:0]     amp_enable_cmd;
    logic [31:0]                            motor_rdata;
    logic [31:0]                            board_rdata;

    // ----------------------------------------
    // channel and board registers
    // ----------------------------------------
    motor_cmd_regs u_motor (
        .sysclk          (sysclk),
        .rst             (rst),
        .reg_waddr       (reg_waddr),
        .reg_wdata       (reg_wdata),
        .reg_wen         (reg_wen),
        .reg_raddr       (reg_raddr),
        .amp_fault       (amp_fault),
        .pwr_enable      (pwr_enable),
        .wdog_timeout    (wdog_timeout),
        .dac_busy        (dac_busy),
        .cur_cmd         (cur_cmd),
        .cur_cmd_updated (cur_cmd_updated),
        .amp_enable_cmd  (amp_enable_cmd),
        .amp_disable     (amp_disable),
        .motor_rdata     (motor_rdata)
    );

    board_regs u_board (
        .sysclk          (sysclk),
        .rst             (rst),
        .reg_waddr       (reg_waddr),
        .reg_wdata       (reg_wdata),
        .reg_wen         (reg_wen),
        .board_id        (board_id),
        .amp_fault       (amp_fault),
        .wdog_timeout    (wdog_timeout),
        .amp_enable_cmd  (amp_enable_cmd),
        .pwr_enable      (pwr_enable),
        .wdog_clear      (wdog_clear),
        .board_rdata     (board_rdata)
    );

    // ----------------------------------------
    // dac link and read path
    // ----------------------------------------
    dac_spi_ctrl #(
        .SCLK_DIV (SCLK_DIV)
    ) u_dac (
        .sysclk          (sysclk),
        .rst             (rst),
        .cur_cmd         (cur_cmd),
        .cur_cmd_updated (cur_cmd_updated),
        .dac_busy        (dac_busy),
        .dac_sclk        (dac_sclk),
        .dac_mosi        (dac_mosi),
        .dac_csel        (dac_csel)
    );

    reg_read_mux u_rmux (
        .reg_raddr       (reg_raddr),
        .motor_rdata     (motor_rdata),
        .board_rdata     (board_rdata),
        .reg_rdata       (reg_rdata)
    );

endmodule

`default_nettype wire

/* dv/qla_core_sva.sv */
// checks on the dac serial link of dac_spi_ctrl
// inactive while rst is high
`default_nettype none

module qla_core_sva (
    input logic sysclk,
    input logic rst,
    input logic dac_busy,
    input logic dac_sclk,
    input logic dac_mosi,
    input logic dac_csel
);

    timeunit 1ns;
    timeprecision 100ps;

    logic csel_fail = 1'b0;
    logic sclk_fail = 1'b0;
    logic mosi_fail = 1'b0;
    logic any_fail;             // seen by the testbench

    assign any_fail = csel_fail | sclk_fail | mosi_fail;

    // ----------------------------------------
    // link protocol
    // ----------------------------------------
    csel_needs_busy: assert property (@(posedge sysclk) disable iff (rst)
        !dac_csel |-> dac_busy)
    else begin
        csel_fail = 1'b1;
        $error("dac_csel low while dac_busy is low");
    end

    // no clock edges outside a word
    sclk_quiet: assert property (@(posedge sysclk) disable iff (rst)
        dac_csel |-> !dac_sclk)
    else begin
        sclk_fail = 1'b1;
        $error("dac_sclk high while dac_csel is high");
    end

    // data only moves on the falling edge
    mosi_stable: assert property (@(posedge sysclk) disable iff (rst)
        dac_sclk |=> (!dac_sclk || $stable(dac_mosi)))
    else begin
        mosi_fail = 1'b1;
        $error("dac_mosi changed while dac_sclk is high");
    end

endmodule

`default_nettype wire

/* dv/qla_core_tb.sv */
// testbench for qla_core at SCLK_DIV 2
// dac words are checked against a reference built from the frame format
// the first failure stops the run
`default_nettype none

module qla_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SCLK_DIV  = 2;
    localparam int NCH       = 4;
    localparam int WORD_BITS = 24;
    localparam logic [3:0] DAC_CMD = 4'b0011;   // write and update
    // -------- run length limit --------
    localparam int WORD_CYC    = 2 * SCLK_DIV * WORD_BITS + SCLK_DIV;  // bits plus gap
    localparam int FRAME_CYC   = NCH * WORD_CYC;
    localparam int NUM_FRAMES  = 3;
    localparam int TIMEOUT_CYC = 2 * NUM_FRAMES * FRAME_CYC + 600;    // near 3000

    logic           sysclk;
    logic           rst;
    logic [3:0]     board_id;
    logic [15:0]    reg_waddr;
    logic [31:0]    reg_wdata;
    logic           reg_wen;
    logic [15:0]    reg_raddr;
    logic [NCH-1:0] amp_fault;
    logic           wdog_timeout;
    logic [31:0]    reg_rdata;
    logic           pwr_enable;
    logic [NCH-1:0] amp_disable;
    logic           wdog_clear;
    logic           dac_sclk;
    logic           dac_mosi;
    logic           dac_csel;
    logic           dac_busy;

    // expected state of the registers
    logic [15:0]           model_cmd [NCH];
    logic [NCH-1:0]        model_en;
    logic                  model_pwr;
    logic [WORD_BITS-1:0]  exp_words [$];   // words still due on the link
    logic [WORD_BITS-1:0]  mon_word;
    int                    mon_bits   = 0;
    int                    words_seen = 0;
    int                    cycles     = 0;

    qla_core #(
        .SCLK_DIV (SCLK_DIV)
    ) qla_core_inst (
        .sysclk       (sysclk),
        .rst          (rst),
        .board_id     (board_id),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .reg_wen      (reg_wen),
        .reg_raddr    (reg_raddr),
        .amp_fault    (amp_fault),
        .wdog_timeout (wdog_timeout),
        .reg_rdata    (reg_rdata),
        .pwr_enable   (pwr_enable),
        .amp_disable  (amp_disable),
        .wdog_clear   (wdog_clear),
        .dac_sclk     (dac_sclk),
        .dac_mosi     (dac_mosi),
        .dac_csel     (dac_csel),
        .dac_busy     (dac_busy)
    );

    bind dac_spi_ctrl qla_core_sva sva_inst (
        .sysclk   (sysclk),
        .rst      (rst),
        .dac_busy (dac_busy),
        .dac_sclk (dac_sclk),
        .dac_mosi (dac_mosi),
        .dac_csel (dac_csel)
    );

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;    // 4 ns period
    end

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    // code, dac index from 0, then the command
    function automatic logic [WORD_BITS-1:0] dac_ref_word(input int ch,
                                                          input logic [15:0] cmd);
        logic [3:0] idx;
        idx = 4'(ch - 1);                   // dac a is motor 1
        return {DAC_CMD, idx, cmd};
    endfunction

    function automatic logic [31:0] expected_read(input logic [15:0] addr);
        logic [31:0] d;
        int          ch;
        d  = '0;
        ch = int'(addr[7:4]);
        if (addr[15:12] != 4'h0) begin
            d = '0;                         // other spaces read 0
        end else if (ch == 0 && addr[3:0] == 4'd0) begin
            d[0]     = model_pwr;
            d[1]     = wdog_timeout;
            d[11:8]  = amp_fault;
            d[27:24] = board_id;
        end else if (ch >= 1 && ch <= NCH && addr[3:0] == 4'd1) begin
            d[15:0] = model_cmd[ch-1];
        end else if (ch >= 1 && ch <= NCH && addr[3:0] == 4'd2) begin
            d[0] = model_en[ch-1];
            d[1] = amp_fault[ch-1];
        end
        return d;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // ----------------------------------------
    // bus tasks, entered 1 ns after an edge
    // ----------------------------------------
    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        @(posedge sysclk);
        #1;
        reg_wen   = 1'b0;                   // one cycle strobe
    endtask

    task automatic read_reg(input logic [15:0] addr, output logic [31:0] data);
        reg_raddr = addr;
        @(negedge sysclk);                  // rdata settled mid cycle
        data = reg_rdata;
        @(posedge sysclk);
        #1;
    endtask

    task automatic check_outputs(input string tag);
        check_value({tag, " pwr_enable"}, 32'(model_pwr), 32'(pwr_enable));
        check_value({tag, " amp_disable"}, {28'd0, ~model_en}, 32'(amp_disable));
    endtask

    task automatic check_all_regs(input string tag);
        logic [15:0] addrs [$];
        logic [31:0] rd;
        addrs = '{16'h0000, 16'h0001, 16'h0051, 16'h0052, 16'h1011, 16'h1000};
        for (int ch = 1; ch <= NCH; ch++) begin
            addrs.push_back(16'(ch * 16 + 1));
            addrs.push_back(16'(ch * 16 + 2));
        end
        foreach (addrs[i]) begin
            read_reg(addrs[i], rd);
            check_value($sformatf("%s read %h", tag, addrs[i]), expected_read(addrs[i]), rd);
        end
        check_outputs(tag);
    endtask

    task automatic push_frame();
        for (int ch = 1; ch <= NCH; ch++) begin
            exp_words.push_back(dac_ref_word(ch, model_cmd[ch-1]));
        end
    endtask

    task automatic wait_busy(input logic level);
        while (dac_busy !== level) begin
            @(posedge sysclk);
            #1;
        end
    endtask

    task automatic ensure_idle(input int n);
        repeat (n) begin
            @(posedge sysclk);
            #1;
            check_value("no extra frame dac_busy", 0, 32'(dac_busy));
        end
    endtask

    // ----------------------------------------
    // link monitor and comparison
    // ----------------------------------------
    always @(posedge dac_sclk) begin
        if (!dac_csel) begin
            mon_word = {mon_word[WORD_BITS-2:0], dac_mosi};
            mon_bits++;
            if (mon_bits == WORD_BITS) begin
                mon_bits = 0;
                words_seen++;
                if (exp_words.size() == 0) begin
                    fail_run("a DAC word arrived while no frame was expected");
                end else begin
                    check_value($sformatf("dac word %0d", words_seen),
                                32'(exp_words.pop_front()), 32'(mon_word));
                end
            end
        end
    end

    always @(posedge dac_csel) begin
        if (mon_bits != 0) begin
            fail_run($sformatf("DAC word cut short after %0d bits", mon_bits));
        end
    end

    // run limit and bound assertion state
    always @(posedge sysclk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYC) begin
            fail_run($sformatf("timeout after %0d cycles", cycles));
        end else if (qla_core_inst.u_dac.sva_inst.any_fail) begin
            fail_run("an assertion on the DAC serial link failed");
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin
        logic [15:0] val;
        logic [31:0] rd;
        void'($urandom(10));
        rst          = 1'b1;
        board_id     = 4'ha;
        reg_waddr    = '0;
        reg_wdata    = '0;
        reg_wen      = 1'b0;
        reg_raddr    = '0;
        amp_fault    = 4'b1011;             // amp 3 faulted
        wdog_timeout = 1'b0;
        model_pwr    = 1'b0;
        model_en     = '0;
        foreach (model_cmd[i]) model_cmd[i] = '0;
        repeat (10) @(posedge sysclk);
        #1;
        rst = 1'b0;

        // reset values
        check_value("reset dac_csel", 1, 32'(dac_csel));
        check_value("reset dac_sclk", 0, 32'(dac_sclk));
        check_value("reset dac_busy", 0, 32'(dac_busy));
        check_value("reset wdog_clear", 0, 32'(wdog_clear));
        check_all_regs("reset");

        // decoding, commands without update
        for (int ch = 1; ch <= NCH; ch++) begin
            val = 16'($urandom);
            write_reg(16'(ch * 16 + 1), {16'h0000, val});
            model_cmd[ch-1] = val;
        end
        write_reg(16'h0001, 32'h0000_1234);     // channel 0 has no command
        write_reg(16'h0051, 32'h0000_5555);     // channel 5 out of range
        write_reg(16'h1011, 32'h0000_beef);     // other space
        write_reg(16'h1000, 32'h000c_0000);
        check_all_regs("decode");
        check_value("decode dac_busy", 0, 32'(dac_busy));

        // enables
        write_reg(16'h0012, 32'h0000_0300);     // amp 1 without power
        check_value("amp before power wdog_clear", 1, 32'(wdog_clear));
        check_outputs("amp before power");
        @(posedge sysclk);
        #1;
        check_value("wdog_clear pulse end", 0, 32'(wdog_clear));
        write_reg(16'h0000, 32'h000c_0000);     // power on
        model_pwr = 1'b1;
        check_value("power wdog_clear", 1, 32'(wdog_clear));
        check_outputs("power on");
        write_reg(16'h0012, 32'h0000_0300);
        model_en[0] = 1'b1;
        check_value("amp 1 wdog_clear", 1, 32'(wdog_clear));
        check_outputs("amp 1 on");
        write_reg(16'h0032, 32'h0000_0300);
        model_en[2] = 1'b1;
        check_outputs("amp 3 on");
        write_reg(16'h0022, 32'h0000_0100);     // mask clear
        check_value("unmasked wdog_clear", 0, 32'(wdog_clear));
        check_outputs("unmasked amp write");
        write_reg(16'h0032, 32'h0000_0200);
        model_en[2] = 1'b0;
        check_all_regs("enables");
        wdog_timeout = 1'b1;
        read_reg(16'h0000, rd);                 // sampled before the clearing edge
        check_value("timeout status", expected_read(16'h0000), rd);
        model_pwr    = 1'b0;
        model_en     = '0;
        wdog_timeout = 1'b0;
        check_all_regs("timeout");

        // one dac frame
        for (int ch = 1; ch < NCH; ch++) begin
            val = 16'($urandom);
            write_reg(16'(ch * 16 + 1), {16'h0000, val});
            model_cmd[ch-1] = val;
        end
        val = 16'($urandom);
        model_cmd[NCH-1] = val;
        push_frame();
        write_reg(16'h0041, {16'h8000, val});
        wait_busy(1'b1);
        wait_busy(1'b0);
        check_value("frame words", 4, 32'(words_seen));
        check_value("frame words left", 0, 32'(exp_words.size()));
        ensure_idle(20);

        // two updates during a frame give one more
        val = 16'($urandom);
        model_cmd[0] = val;
        push_frame();
        write_reg(16'h0011, {16'h8000, val});
        wait_busy(1'b1);
        val = 16'($urandom);
        model_cmd[1] = val;
        write_reg(16'h0021, {16'h8000, val});
        val = 16'($urandom);
        model_cmd[2] = val;
        write_reg(16'h0031, {16'h8000, val});
        push_frame();                           // latest values only
        check_value("pending dac_busy", 1, 32'(dac_busy));
        wait_busy(1'b0);
        wait_busy(1'b1);
        wait_busy(1'b0);
        check_value("pending words", 12, 32'(words_seen));
        check_value("pending words left", 0, 32'(exp_words.size()));
        ensure_idle(20);
        check_all_regs("final");

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* qla_core.f */
hdl/qla_regmap_pkg.sv
hdl/qla_motor_pkg.sv
hdl/motor_cmd_regs.sv
hdl/dac_spi_ctrl.sv
hdl/board_regs.sv
hdl/reg_read_mux.sv
hdl/qla_core.sv
dv/qla_core_sva.sv
dv/qla_core_tb.sv

/* Makefile */
# Verilator build of the qla_core testbench
TOP = qla_core_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f qla_core.f --Mdir obj_dir -o qla_core_sim
	./obj_dir/qla_core_sim

clean:
	rm -rf obj_dir
